// ==== verilog/isa_pkg.sv ====
package isa_pkg;

	localparam int DATA_W = 8; // opcode width

	// opcode bytes still decoded
	typedef enum logic [DATA_W-1:0] {
		OPC_ADC_IMM = 8'h69, // adc #imm
		OPC_SBC_IMM = 8'he9, // sbc #imm
		OPC_ADC_ZPG = 8'h65, // adc zp
		OPC_ADC_ABS = 8'h6d, // adc abs
		OPC_SEC     = 8'h38, // set carry
		OPC_CLC     = 8'h18, // clear carry
		OPC_INX     = 8'he8,
		OPC_DEX     = 8'hca,
		OPC_INY     = 8'hc8,
		OPC_DEY     = 8'h88,
		OPC_TAX     = 8'haa,
		OPC_TXA     = 8'h8a,
		OPC_TAY     = 8'ha8,
		OPC_TYA     = 8'h98
	} opcode_e;

	// one class per distinct control sequence
	typedef enum logic [3:0] {
		OP_NONE,    // anything not decoded
		OP_ADC_IMM,
		OP_SBC_IMM,
		OP_ADC_ZPG,
		OP_ADC_ABS,
		OP_FLAG_C,  // sec and clc share one path, ir bit 5 picks
		OP_INX,
		OP_DEX,
		OP_INY,
		OP_DEY,
		OP_TAX,
		OP_TXA,
		OP_TAY,
		OP_TYA
	} op_class_e;

endpackage

// ==== verilog/decode_pkg.sv ====
package decode_pkg;

	// instruction cycle numbers
	localparam int CYC_FETCH   = 0; // opcode on the data bus
	localparam int CYC_OPERAND = 1; // first operand byte
	localparam int CYC_ADDR    = 2; // address high byte or zp data
	localparam int CYC_EXEC    = 3; // abs data
	localparam int CYC_LAST    = CYC_EXEC; // highest cycle with its own decode

	// what the cycle counter does next
	typedef enum logic [1:0] {
		CTR_HOLD,    // undecoded, no strobe
		CTR_ADVANCE, // pulse i_cycle
		CTR_RESTART  // pulse r_cycle
	} ctr_step_e;

	// who drives the address bus next
	typedef enum logic [1:0] {
		ADDR_NONE, // latches closed
		ADDR_PC,   // program counter
		ADDR_ZPG,  // dl low, zero high
		ADDR_ABS   // alu low, dl high
	} addr_src_e;

endpackage

// ==== verilog/decode_ifs.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// address bus source and latch controls
////////////////////////////////////////////////////////////
interface addr_ctrl_if;
	logic pcl_adl; // pc low onto adl
	logic pch_adh; // pc high onto adh
	logic dl_adl;  // data latch onto adl
	logic dl_adh;  // data latch onto adh
	logic z_adh;   // zeros onto adh
	logic add_adl; // alu hold reg onto adl
	logic adl_abl; // latch adl into abl
	logic adh_abh; // latch adh into abh

	modport src (output pcl_adl, pch_adh, dl_adl, dl_adh, z_adh, add_adl, adl_abl, adh_abh);
	modport dst (input pcl_adl, pch_adh, dl_adl, dl_adh, z_adh, add_adl, adl_abl, adh_abh);
endinterface

////////////////////////////////////////////////////////////
// internal bus transfers
////////////////////////////////////////////////////////////
interface xfer_ctrl_if;
	logic dl_db, ac_sb, ac_db, add_sb; // sources onto db/sb
	logic sb_ac, sb_db, sb_x, sb_y;    // sb sinks
	logic x_sb, y_sb;                  // index regs onto sb

	modport src (output dl_db, ac_sb, ac_db, add_sb, sb_ac, sb_db, sb_x, sb_y, x_sb, y_sb);
	modport dst (input dl_db, ac_sb, ac_db, add_sb, sb_ac, sb_db, sb_x, sb_y, x_sb, y_sb);
endinterface

////////////////////////////////////////////////////////////
// alu input select, operation and flag loads
////////////////////////////////////////////////////////////
interface alu_ctrl_if;
	logic db_add, ndb_add, sb_add; // b input db, ~db; a input sb
	logic z_add, none_add;         // a input zero or all ones
	logic c_one, sums;             // carry in, add op
	logic avr_v, acr_c, dbz_z, db7_n, ir5_c; // status flag loads

	modport src (output db_add, ndb_add, sb_add, z_add, c_one, none_add, sums,
		avr_v, acr_c, dbz_z, db7_n, ir5_c);
	modport dst (input db_add, ndb_add, sb_add, z_add, c_one, none_add, sums,
		avr_v, acr_c, dbz_z, db7_n, ir5_c);
endinterface

// ==== verilog/op_classify.sv ====
`timescale 1ns/1ps

module op_classify (
	input  logic [isa_pkg::DATA_W-1:0] ir,          // instruction register
	output isa_pkg::op_class_e         op_class,    // decoded behavior
	output logic                       single_byte  // no operand byte follows
);
	import isa_pkg::*;

	// opcode byte lookup
	always_comb begin
		case (ir)
			OPC_ADC_IMM: op_class = OP_ADC_IMM;
			OPC_SBC_IMM: op_class = OP_SBC_IMM;
			OPC_ADC_ZPG: op_class = OP_ADC_ZPG;
			OPC_ADC_ABS: op_class = OP_ADC_ABS;
			OPC_SEC,
			OPC_CLC:     op_class = OP_FLAG_C; // bit 5 tells them apart later
			OPC_INX:     op_class = OP_INX;
			OPC_DEX:     op_class = OP_DEX;
			OPC_INY:     op_class = OP_INY;
			OPC_DEY:     op_class = OP_DEY;
			OPC_TAX:     op_class = OP_TAX;
			OPC_TXA:     op_class = OP_TXA;
			OPC_TAY:     op_class = OP_TAY;
			OPC_TYA:     op_class = OP_TYA;
			default:     op_class = OP_NONE; // indexed modes land here too
		endcase
	end

	// implied-mode ops have no operand for the pc to step past
	always_comb begin
		case (op_class)
			OP_FLAG_C,
			OP_INX,
			OP_DEX,
			OP_INY,
			OP_DEY,
			OP_TAX,
			OP_TXA,
			OP_TAY,
			OP_TYA:  single_byte = 1'b1;
			default: single_byte = 1'b0;
		endcase
	end

endmodule

// ==== verilog/cycle_sequencer.sv ====
`timescale 1ns/1ps

module cycle_sequencer #(
	parameter int CYCLE_W = 3 // cycle input width
) (
	input  logic               clk_ph2,     // clock phase 2
	input  logic               rst,         // sync reset, active low
	input  logic [CYCLE_W-1:0] cycle,       // current instruction cycle
	input  isa_pkg::op_class_e op_class,    // decoded opcode class
	input  logic               single_byte, // implied-mode opcode
	output logic               i_cycle,     // advance cycle counter
	output logic               r_cycle,     // return cycle counter to 0
	output logic               i_pc,        // pc increment after gating
	output logic               pcl_pcl,     // pc low feedback
	output logic               pch_pch      // pc high feedback
);
	import isa_pkg::*;
	import decode_pkg::*;

	ctr_step_e ctr_d;     // counter action for the sampled cycle
	logic      pc_step_d; // pc steps after this cycle
	logic      past_last; // cycle beyond the decoded range
	logic      pc_inc_q;  // registered increment, before gating

	assign past_last = (cycle > CYCLE_W'(CYC_LAST));

	always_comb begin
		ctr_d     = CTR_HOLD; // undecoded pairs drive nothing
		pc_step_d = 1'b0;
		if (past_last) begin
			ctr_d     = CTR_RESTART; // stray count refetches from cycle 0
			pc_step_d = 1'b1;
		end else begin
			case (cycle)
				CYCLE_W'(CYC_FETCH): begin
					ctr_d     = CTR_ADVANCE; // opcode fetch always moves on
					pc_step_d = 1'b1;
				end
				CYCLE_W'(CYC_OPERAND): begin
					case (op_class)
						OP_NONE:    ctr_d = CTR_HOLD;
						OP_ADC_ZPG: ctr_d = CTR_ADVANCE; // bus goes to zp while pc waits
						OP_ADC_ABS: begin
							ctr_d     = CTR_ADVANCE; // fetch address high byte
							pc_step_d = 1'b1;
						end
						default: begin
							ctr_d     = CTR_RESTART; // two-cycle ops end here
							pc_step_d = 1'b1;
						end
					endcase
				end
				CYCLE_W'(CYC_ADDR): begin
					if (op_class == OP_ADC_ABS) begin
						ctr_d = CTR_ADVANCE; // data read leaves pc untouched
					end else if (op_class == OP_ADC_ZPG) begin
						ctr_d     = CTR_RESTART;
						pc_step_d = 1'b1;
					end
				end
				CYCLE_W'(CYC_EXEC): begin
					if (op_class == OP_ADC_ABS) begin
						ctr_d     = CTR_RESTART;
						pc_step_d = 1'b1;
					end
				end
				default: ctr_d = CTR_HOLD;
			endcase
		end
	end

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			i_cycle  <= 1'b0;
			r_cycle  <= 1'b0;
			pc_inc_q <= 1'b0;
			pcl_pcl  <= 1'b0;
			pch_pch  <= 1'b0;
		end else begin
			i_cycle  <= (ctr_d == CTR_ADVANCE);
			r_cycle  <= (ctr_d == CTR_RESTART);
			pc_inc_q <= pc_step_d;
			pcl_pcl  <= pc_step_d; // pc regs reload through the incrementer
			pch_pch  <= pc_step_d;
		end
	end

	// 1-byte ops have no operand byte for the pc to skip
	assign i_pc = (cycle == CYCLE_W'(CYC_OPERAND) && single_byte) ? 1'b0 : pc_inc_q;

endmodule

// ==== verilog/address_decoder.sv ====
`timescale 1ns/1ps

module address_decoder #(
	parameter int CYCLE_W = 3 // cycle input width
) (
	input  logic               clk_ph2,  // clock phase 2
	input  logic               rst,      // sync reset, active low
	input  logic [CYCLE_W-1:0] cycle,    // current instruction cycle
	input  isa_pkg::op_class_e op_class, // decoded opcode class
	addr_ctrl_if.src           addr      // address bus controls
);
	import isa_pkg::*;
	import decode_pkg::*;

	addr_src_e src_d; // address source for the next cycle

	always_comb begin
		src_d = ADDR_NONE;
		case (cycle)
			CYCLE_W'(CYC_FETCH): src_d = ADDR_PC; // next byte from pc
			CYCLE_W'(CYC_OPERAND): begin
				case (op_class)
					OP_NONE:    src_d = ADDR_NONE;
					OP_ADC_ZPG: src_d = ADDR_ZPG; // operand is the zp address
					default:    src_d = ADDR_PC;
				endcase
			end
			CYCLE_W'(CYC_ADDR): begin
				if (op_class == OP_ADC_ABS)
					src_d = ADDR_ABS; // low byte parked in alu
				else if (op_class == OP_ADC_ZPG)
					src_d = ADDR_PC;  // back to opcode fetch
			end
			CYCLE_W'(CYC_EXEC): begin
				if (op_class == OP_ADC_ABS)
					src_d = ADDR_PC;
			end
			default: src_d = ADDR_PC; // out-of-range count refetches
		endcase
	end

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			addr.pcl_adl <= 1'b0;
			addr.pch_adh <= 1'b0;
			addr.dl_adl  <= 1'b0;
			addr.dl_adh  <= 1'b0;
			addr.z_adh   <= 1'b0;
			addr.add_adl <= 1'b0;
			addr.adl_abl <= 1'b0;
			addr.adh_abh <= 1'b0;
		end else begin
			addr.pcl_adl <= (src_d == ADDR_PC);
			addr.pch_adh <= (src_d == ADDR_PC);
			addr.dl_adl  <= (src_d == ADDR_ZPG);
			addr.z_adh   <= (src_d == ADDR_ZPG); // page 0
			addr.dl_adh  <= (src_d == ADDR_ABS);
			addr.add_adl <= (src_d == ADDR_ABS);
			addr.adl_abl <= (src_d != ADDR_NONE); // any source opens both latches
			addr.adh_abh <= (src_d != ADDR_NONE);
		end
	end

endmodule

// ==== verilog/datapath_decoder.sv ====
`timescale 1ns/1ps

module datapath_decoder #(
	parameter int CYCLE_W = 3 // cycle input width
) (
	input  logic               clk_ph2,  // clock phase 2
	input  logic               rst,      // sync reset, active low
	input  logic [CYCLE_W-1:0] cycle,    // current instruction cycle
	input  isa_pkg::op_class_e op_class, // decoded opcode class
	xfer_ctrl_if.src           xfer,     // bus transfers
	alu_ctrl_if.src            alu       // alu and flag controls
);
	import isa_pkg::*;
	import decode_pkg::*;

	logic add_launch; // memory operand ready, add it to the accumulator

	assign add_launch = (cycle == CYCLE_W'(CYC_ADDR) && op_class == OP_ADC_ZPG) ||
		(cycle == CYCLE_W'(CYC_EXEC) && op_class == OP_ADC_ABS);

	always_ff @(posedge clk_ph2) begin
		xfer.dl_db   <= 1'b0; // all lines idle unless decoded below
		xfer.ac_sb   <= 1'b0;
		xfer.ac_db   <= 1'b0;
		xfer.add_sb  <= 1'b0;
		xfer.sb_ac   <= 1'b0;
		xfer.sb_db   <= 1'b0;
		xfer.sb_x    <= 1'b0;
		xfer.sb_y    <= 1'b0;
		xfer.x_sb    <= 1'b0;
		xfer.y_sb    <= 1'b0;
		alu.db_add   <= 1'b0;
		alu.ndb_add  <= 1'b0;
		alu.sb_add   <= 1'b0;
		alu.z_add    <= 1'b0;
		alu.c_one    <= 1'b0;
		alu.none_add <= 1'b0;
		alu.sums     <= 1'b0;
		alu.avr_v    <= 1'b0;
		alu.acr_c    <= 1'b0;
		alu.dbz_z    <= 1'b0;
		alu.db7_n    <= 1'b0;
		alu.ir5_c    <= 1'b0;
		if (rst) begin
			////////////////////////////////////////////////////////////
			// cycle 0 retires the last op and cycle 1 starts the new one
			////////////////////////////////////////////////////////////
			case (cycle)
				CYCLE_W'(CYC_FETCH): begin
					case (op_class)
						OP_ADC_IMM, OP_SBC_IMM, OP_ADC_ZPG, OP_ADC_ABS: begin
							xfer.add_sb <= 1'b1; // sum onto sb
							xfer.sb_ac  <= 1'b1; // into accumulator
							xfer.sb_db  <= 1'b1; // and onto db for n/z
							alu.avr_v   <= 1'b1;
							alu.acr_c   <= 1'b1;
							alu.dbz_z   <= 1'b1;
							alu.db7_n   <= 1'b1;
						end
						OP_INX, OP_DEX, OP_INY, OP_DEY: begin
							xfer.add_sb <= 1'b1;
							xfer.sb_x   <= (op_class == OP_INX) || (op_class == OP_DEX);
							xfer.sb_y   <= (op_class == OP_INY) || (op_class == OP_DEY);
							xfer.sb_db  <= 1'b1;
							alu.dbz_z   <= 1'b1; // c and v untouched by inc/dec
							alu.db7_n   <= 1'b1;
						end
						default: ;
					endcase
				end
				CYCLE_W'(CYC_OPERAND): begin
					case (op_class)
						OP_ADC_IMM, OP_SBC_IMM: begin
							xfer.dl_db  <= 1'b1; // immediate byte
							alu.db_add  <= (op_class == OP_ADC_IMM);
							alu.ndb_add <= (op_class == OP_SBC_IMM); // subtract = add ~m
							xfer.ac_sb  <= 1'b1;
							alu.sb_add  <= 1'b1;
							alu.sums    <= 1'b1;
						end
						OP_FLAG_C: alu.ir5_c <= 1'b1; // sec sets and clc clears
						OP_INX, OP_DEX, OP_INY, OP_DEY: begin
							xfer.x_sb    <= (op_class == OP_INX) || (op_class == OP_DEX);
							xfer.y_sb    <= (op_class == OP_INY) || (op_class == OP_DEY);
							xfer.sb_db   <= 1'b1; // index reaches alu b via db
							alu.db_add   <= 1'b1;
							alu.z_add    <= (op_class == OP_INX) || (op_class == OP_INY);
							alu.none_add <= (op_class == OP_DEX) || (op_class == OP_DEY);
							alu.c_one    <= (op_class == OP_INX) || (op_class == OP_INY); // +1 only
							alu.sums     <= 1'b1;
						end
						OP_TXA, OP_TYA: begin
							xfer.x_sb  <= (op_class == OP_TXA);
							xfer.y_sb  <= (op_class == OP_TYA);
							xfer.sb_db <= 1'b1;
							xfer.sb_ac <= 1'b1; // straight into a past the alu
							alu.dbz_z  <= 1'b1;
							alu.db7_n  <= 1'b1;
						end
						OP_TAX, OP_TAY: begin
							xfer.ac_sb <= 1'b1;
							xfer.ac_db <= 1'b1; // flags watch db
							xfer.sb_x  <= (op_class == OP_TAX);
							xfer.sb_y  <= (op_class == OP_TAY);
							alu.dbz_z  <= 1'b1;
							alu.db7_n  <= 1'b1;
						end
						OP_ADC_ABS: begin
							xfer.dl_db <= 1'b1; // address low byte
							alu.db_add <= 1'b1;
							alu.z_add  <= 1'b1; // plus 0 keeps it in the alu
							alu.sums   <= 1'b1;
						end
						default: ;
					endcase
				end
				default: ;
			endcase
			if (add_launch) begin
				xfer.dl_db <= 1'b1; // fetched data
				alu.db_add <= 1'b1;
				xfer.ac_sb <= 1'b1;
				alu.sb_add <= 1'b1;
				alu.sums   <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder #(
	parameter int CYCLE_W = 3 // cycle counter width
) (
	input  logic                        clk_ph2, // clock phase 2
	input  logic                        rst,     // sync reset, active low
	input  logic [CYCLE_W-1:0]          cycle,   // current instruction cycle
	input  logic [isa_pkg::DATA_W-1:0]  ir,      // instruction register
	output logic                        i_cycle, // cycle counter advance
	output logic                        r_cycle, // cycle counter restart
	output logic                        i_pc,    // pc increment
	output logic                        pcl_pcl,
	output logic                        pch_pch,
	// address bus
	output logic pcl_adl, pch_adh, dl_adl, dl_adh,
	output logic z_adh, add_adl, adl_abl, adh_abh,
	// internal buses
	output logic dl_db, ac_sb, ac_db, add_sb, sb_ac,
	output logic sb_db, sb_x, sb_y, x_sb, y_sb,
	// alu inputs and op
	output logic db_add, ndb_add, sb_add, z_add,
	output logic c_one, none_add, sums,
	// status flags
	output logic avr_v, acr_c, dbz_z, db7_n, ir5_c
);
	import isa_pkg::*;

	op_class_e op_class;    // shared by all three decoders
	logic      single_byte; // only the sequencer needs it

	addr_ctrl_if u_addr_if ();
	xfer_ctrl_if u_xfer_if ();
	alu_ctrl_if  u_alu_if ();

	////////////////////////////////////////////////////////////
	// decode blocks
	////////////////////////////////////////////////////////////
	op_classify u_op_classify (
		.ir          (ir),
		.op_class    (op_class),
		.single_byte (single_byte)
	);

	cycle_sequencer #(.CYCLE_W(CYCLE_W)) u_cycle_sequencer (
		.clk_ph2     (clk_ph2),
		.rst         (rst),
		.cycle       (cycle),
		.op_class    (op_class),
		.single_byte (single_byte),
		.i_cycle     (i_cycle),
		.r_cycle     (r_cycle),
		.i_pc        (i_pc),
		.pcl_pcl     (pcl_pcl),
		.pch_pch     (pch_pch)
	);

	address_decoder #(.CYCLE_W(CYCLE_W)) u_address_decoder (
		.clk_ph2  (clk_ph2),
		.rst      (rst),
		.cycle    (cycle),
		.op_class (op_class),
		.addr     (u_addr_if.src)
	);

	datapath_decoder #(.CYCLE_W(CYCLE_W)) u_datapath_decoder (
		.clk_ph2  (clk_ph2),
		.rst      (rst),
		.cycle    (cycle),
		.op_class (op_class),
		.xfer     (u_xfer_if.src),
		.alu      (u_alu_if.src)
	);

	////////////////////////////////////////////////////////////
	// flatten the groups onto the pins
	////////////////////////////////////////////////////////////
	assign pcl_adl  = u_addr_if.pcl_adl;
	assign pch_adh  = u_addr_if.pch_adh;
	assign dl_adl   = u_addr_if.dl_adl;
	assign dl_adh   = u_addr_if.dl_adh;
	assign z_adh    = u_addr_if.z_adh;
	assign add_adl  = u_addr_if.add_adl;
	assign adl_abl  = u_addr_if.adl_abl;
	assign adh_abh  = u_addr_if.adh_abh;

	assign dl_db    = u_xfer_if.dl_db;
	assign ac_sb    = u_xfer_if.ac_sb;
	assign ac_db    = u_xfer_if.ac_db;
	assign add_sb   = u_xfer_if.add_sb;
	assign sb_ac    = u_xfer_if.sb_ac;
	assign sb_db    = u_xfer_if.sb_db;
	assign sb_x     = u_xfer_if.sb_x;
	assign sb_y     = u_xfer_if.sb_y;
	assign x_sb     = u_xfer_if.x_sb;
	assign y_sb     = u_xfer_if.y_sb;

	assign db_add   = u_alu_if.db_add;
	assign ndb_add  = u_alu_if.ndb_add;
	assign sb_add   = u_alu_if.sb_add;
	assign z_add    = u_alu_if.z_add;
	assign c_one    = u_alu_if.c_one;
	assign none_add = u_alu_if.none_add;
	assign sums     = u_alu_if.sums;
	assign avr_v    = u_alu_if.avr_v;
	assign acr_c    = u_alu_if.acr_c;
	assign dbz_z    = u_alu_if.dbz_z;
	assign db7_n    = u_alu_if.db7_n;
	assign ir5_c    = u_alu_if.ir5_c;

endmodule

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int          NUM_LINES = 34;           // registered control lines
localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1
typedef logic [NUM_LINES-1:0] line_vec_t;

int          mismatch_count = 0;             // wrong output values
int          other_count    = 0;             // anything else that went wrong
logic [31:0] lfsr_state     = 32'h364474cb;  // galois lfsr state

// bit i of a line vector carries line_names[i]
string line_names [NUM_LINES] = '{"i_cycle", "r_cycle", "pcl_pcl", "pch_pch",
	"pcl_adl", "pch_adh", "dl_adl", "dl_adh", "z_adh", "add_adl", "adl_abl", "adh_abh",
	"dl_db", "ac_sb", "ac_db", "add_sb", "sb_ac", "sb_db", "sb_x", "sb_y", "x_sb", "y_sb",
	"db_add", "ndb_add", "sb_add", "z_add", "c_one", "none_add", "sums",
	"avr_v", "acr_c", "dbz_z", "db7_n", "ir5_c"};

task automatic compare_value(string name, logic expected, logic actual);
	if (actual !== expected) begin
		mismatch_count++;
		$display("MISMATCH t=%0t %s expected %b actual %b", $time, name, expected, actual);
	end
endtask

function automatic line_vec_t line_mask(string name);
	for (int i = 0; i < NUM_LINES; i++)
		if (line_names[i] == name)
			return line_vec_t'(1) << i; // one-hot for this line
	other_count++;
	$display("unknown control line %s in an expected set", name);
	return '0;
endfunction

// space separated names to a line vector
function automatic line_vec_t lines_of(string list);
	line_vec_t v;
	int        start;
	v     = '0;
	start = 0;
	for (int i = 0; i <= list.len(); i++) begin
		if (i == list.len() || list[i] == " ") begin
			if (i > start)
				v |= line_mask(list.substr(start, i - 1));
			start = i + 1; // next word
		end
	end
	return v;
endfunction

function automatic logic lfsr_step();
	logic out_bit;
	out_bit    = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (out_bit)
		lfsr_state = lfsr_state ^ LFSR_TAPS; // feedback into the tap positions
	return out_bit;
endfunction

function automatic logic [31:0] draw_bits(int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[30:0], lfsr_step()}; // one lfsr step per bit
	return v;
endfunction

// counter advances while pc steps and drives the address bus
function automatic line_vec_t fetch_lines();
	return lines_of("i_cycle pcl_pcl pch_pch pcl_adl pch_adh adl_abl adh_abh");
endfunction

// counter back to 0 with the next opcode from pc
function automatic line_vec_t restart_lines();
	return lines_of("r_cycle pcl_pcl pch_pch pcl_adl pch_adh adl_abl adh_abh");
endfunction

// alu result into a with all four flags loading
function automatic line_vec_t acc_writeback();
	return lines_of("add_sb sb_ac sb_db avr_v acr_c dbz_z db7_n");
endfunction

// memory byte plus accumulator
function automatic line_vec_t add_launch_lines();
	return lines_of("dl_db db_add ac_sb sb_add sums");
endfunction

`endif

// ==== verif/tb_instruction_decoder.sv ====
`timescale 1ns/1ps

module tb_instruction_decoder;
	import isa_pkg::*;

	`include "tb_checks.svh"

	localparam int CYCLE_W         = 3;
	localparam int NUM_TESTS       = 5;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 64; // tests need about 120

	logic               clk_ph2 = 1'b0;
	logic               rst;
	logic [CYCLE_W-1:0] cycle;
	logic [7:0]         ir;
	logic i_cycle, r_cycle, i_pc, pcl_pcl, pch_pch;
	logic pcl_adl, pch_adh, dl_adl, dl_adh, z_adh, add_adl, adl_abl, adh_abh;
	logic dl_db, ac_sb, ac_db, add_sb, sb_ac, sb_db, sb_x, sb_y, x_sb, y_sb;
	logic db_add, ndb_add, sb_add, z_add, c_one, none_add, sums;
	logic avr_v, acr_c, dbz_z, db7_n, ir5_c;
	line_vec_t actual_lines; // same bit order as line_names

	instruction_decoder #(.CYCLE_W(CYCLE_W)) u_instruction_decoder (.*);

	assign actual_lines = {ir5_c, db7_n, dbz_z, acr_c, avr_v, sums, none_add, c_one,
		z_add, sb_add, ndb_add, db_add, y_sb, x_sb, sb_y, sb_x, sb_db, sb_ac, add_sb,
		ac_db, ac_sb, dl_db, adh_abh, adl_abl, add_adl, z_adh, dl_adh, dl_adl, pch_adh,
		pcl_adl, pch_pch, pcl_pcl, r_cycle, i_cycle};

	always #2 clk_ph2 = ~clk_ph2; // 4 ns period

	task automatic check_outputs(line_vec_t expected, logic exp_i_pc);
		for (int i = 0; i < NUM_LINES; i++)
			compare_value(line_names[i], expected[i], actual_lines[i]);
		compare_value("i_pc", exp_i_pc, i_pc);
	endtask

	task automatic drive_and_check(int cyc, logic [7:0] op, line_vec_t expected, logic exp_i_pc);
		@(posedge clk_ph2);
		cycle <= CYCLE_W'(cyc);
		ir    <= op;
		@(posedge clk_ph2); // dut samples cyc and op
		@(negedge clk_ph2); // registered lines settled while inputs are still held
		check_outputs(expected, exp_i_pc);
	endtask

	task automatic reset_behavior();
		repeat (10) begin
			@(posedge clk_ph2);
			@(negedge clk_ph2);
			check_outputs('0, 1'b0);
		end
		@(posedge clk_ph2);
		rst <= 1'b1;
		@(negedge clk_ph2); // this edge still saw rst low
		check_outputs('0, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// two-cycle register ops hold the pc on cycle 1
	////////////////////////////////////////////////////////////
	task automatic run_register_op(logic [7:0] op, string exec, string writeback);
		drive_and_check(0, op, fetch_lines() | lines_of(writeback), 1'b1);
		drive_and_check(1, op, restart_lines() | lines_of(exec), 1'b0);
		drive_and_check(0, op, fetch_lines() | lines_of(writeback), 1'b1);
	endtask

	task automatic register_ops();
		run_register_op(OPC_INX, "x_sb sb_db db_add z_add c_one sums",
			"add_sb sb_x sb_db dbz_z db7_n");
		run_register_op(OPC_DEX, "x_sb sb_db db_add none_add sums",
			"add_sb sb_x sb_db dbz_z db7_n");
		run_register_op(OPC_INY, "y_sb sb_db db_add z_add c_one sums",
			"add_sb sb_y sb_db dbz_z db7_n");
		run_register_op(OPC_DEY, "y_sb sb_db db_add none_add sums",
			"add_sb sb_y sb_db dbz_z db7_n");
		run_register_op(OPC_TAX, "ac_sb ac_db sb_x dbz_z db7_n", ""); // no write-back
		run_register_op(OPC_TAY, "ac_sb ac_db sb_y dbz_z db7_n", "");
		run_register_op(OPC_TXA, "x_sb sb_db sb_ac dbz_z db7_n", "");
		run_register_op(OPC_TYA, "y_sb sb_db sb_ac dbz_z db7_n", "");
	endtask

	task automatic run_immediate(logic [7:0] op, string b_input);
		drive_and_check(0, op, fetch_lines() | acc_writeback(), 1'b1);
		drive_and_check(1, op, restart_lines() | lines_of({"dl_db sb_add ac_sb sums ", b_input}),
			1'b1); // pc steps past the operand byte
		drive_and_check(0, op, fetch_lines() | acc_writeback(), 1'b1);
	endtask

	task automatic immediate_ops();
		run_immediate(OPC_ADC_IMM, "db_add");
		run_immediate(OPC_SBC_IMM, "ndb_add"); // inverted operand
	endtask

	task automatic flag_and_memory_ops();
		drive_and_check(0, OPC_SEC, fetch_lines(), 1'b1);
		drive_and_check(1, OPC_SEC, restart_lines() | lines_of("ir5_c"), 1'b0);
		drive_and_check(0, OPC_CLC, fetch_lines(), 1'b1);
		drive_and_check(1, OPC_CLC, restart_lines() | lines_of("ir5_c"), 1'b0);
		// zero page reads its data from page 0 then adds
		drive_and_check(0, OPC_ADC_ZPG, fetch_lines() | acc_writeback(), 1'b1);
		drive_and_check(1, OPC_ADC_ZPG, lines_of("i_cycle dl_adl z_adh adl_abl adh_abh"), 1'b0);
		drive_and_check(2, OPC_ADC_ZPG, restart_lines() | add_launch_lines(), 1'b1);
		drive_and_check(0, OPC_ADC_ZPG, fetch_lines() | acc_writeback(), 1'b1);
		// absolute parks the low byte in the alu while the high byte is fetched
		drive_and_check(0, OPC_ADC_ABS, fetch_lines() | acc_writeback(), 1'b1);
		drive_and_check(1, OPC_ADC_ABS, fetch_lines() | lines_of("dl_db db_add z_add sums"), 1'b1);
		drive_and_check(2, OPC_ADC_ABS, lines_of("i_cycle dl_adh add_adl adl_abl adh_abh"), 1'b0);
		drive_and_check(3, OPC_ADC_ABS, restart_lines() | add_launch_lines(), 1'b1);
		drive_and_check(0, OPC_ADC_ABS, fetch_lines() | acc_writeback(), 1'b1);
	endtask

	function automatic logic is_kept(logic [7:0] b);
		case (b)
			OPC_ADC_IMM, OPC_SBC_IMM, OPC_ADC_ZPG, OPC_ADC_ABS, OPC_SEC, OPC_CLC,
			OPC_INX, OPC_DEX, OPC_INY, OPC_DEY, OPC_TAX, OPC_TXA, OPC_TAY, OPC_TYA:
				return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic undecoded_inputs();
		logic [31:0] r;
		int          cyc;
		repeat (3) begin
			do
				r = draw_bits(8);
			while (is_kept(r[7:0])); // only bytes outside the decoded set
			drive_and_check(0, r[7:0], fetch_lines(), 1'b1);
			drive_and_check(1, r[7:0], '0, 1'b0); // nothing decoded
		end
		repeat (3) begin
			r   = draw_bits(8);
			cyc = 4 + int'(draw_bits(2)); // stray count 4..7
			drive_and_check(cyc, r[7:0], restart_lines(), 1'b1);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_ph2);
		$display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rst   = 1'b0;
		cycle = '0;
		ir    = OPC_ADC_IMM; // would decode if reset failed
		reset_behavior();
		register_ops();
		immediate_ops();
		flag_and_memory_ops();
		undecoded_inputs();
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
verilog/isa_pkg.sv
verilog/decode_pkg.sv
verilog/decode_ifs.sv
verilog/op_classify.sv
verilog/cycle_sequencer.sv
verilog/address_decoder.sv
verilog/datapath_decoder.sv
verilog/instruction_decoder.sv
verif/tb_instruction_decoder.sv

// ==== run.sh ====
#!/bin/sh
# build and run the instruction decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_instruction_decoder -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_instruction_decoder)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx 'PASS: all tests'; then
	exit 0
fi
exit 1
